// File: vlog.f
verilog/fpu_misc_pkg.sv
verilog/flow_stage.sv
verilog/fp_unpack.sv
verilog/int_to_float.sv
verilog/fp_convert.sv
verilog/fp_misc_unit.sv
dv/fp_misc_unit_assertions.sv
dv/fp_misc_unit_tb.sv

// File: Makefile
TOP := fp_misc_unit_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir $(LOG)

// File: dv/fp_misc_unit_tb.sv
module fp_misc_unit_tb
    import fpu_misc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'h1418021a;
    localparam int N_RAW = 8;
    localparam int N_PAIRS = 12;
    localparam int N_CNV_FIXED = 7;
    localparam int N_CNV_RANDOM = 16;
    localparam int N_BURST = 60;
    localparam int N_STREAM = 20;
    localparam int TOTAL_CMDS = N_RAW + 2 * N_PAIRS + N_CNV_FIXED + N_CNV_RANDOM
                                + N_BURST + N_STREAM;
    // Four clock periods per command, with slack for reset and draining.
    localparam int WATCHDOG_NS = (TOTAL_CMDS + 100) * 4 * 4;

    localparam logic [31:0] RAW_PATTERNS [N_RAW] = '{
        32'h3f800000, 32'hbf800000, 32'h7f800000, 32'h7fc00000,
        32'hff800001, 32'h00000001, 32'h80000000, 32'h12345678
    };
    // Mixed signs, negatives, signed zeros, infinities, subnormals, equal, NaNs.
    localparam logic [31:0] PAIR_A [N_PAIRS] = '{
        32'h3f800000, 32'hc0000000, 32'h00000000, 32'h80000000,
        32'h7f800000, 32'h7f800000, 32'h00000001, 32'h80000003,
        32'h40490fdb, 32'h7fc00000, 32'h3f800000, 32'hffc00000
    };
    localparam logic [31:0] PAIR_B [N_PAIRS] = '{
        32'hbf800000, 32'hbf800000, 32'h80000000, 32'h00000000,
        32'hff800000, 32'h42c80000, 32'h00000002, 32'h00000001,
        32'h40490fdb, 32'h3f800000, 32'h7f800001, 32'h7fc00000
    };
    localparam logic [31:0] CNV_VALUES [N_CNV_FIXED] = '{
        32'h00000000, 32'h00000001, 32'hffffffff, 32'h80000000,
        32'h80000000, 32'hffffffff, 32'h7fffffff
    };
    localparam logic CNV_SIGNED [N_CNV_FIXED] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};

    logic clk = 1'b0;
    logic rst_n;
    logic cmd_valid;
    logic cmd_ready;
    fp_request_t cmd;
    logic result_valid;
    logic result_ready = 1'b0;
    fp_result_t result;

    fp_result_t expected_q[$];
    logic [31:0] operand_state = SEED;
    logic [31:0] ready_state = SEED;
    logic [7:0] tag_counter = 8'd0;
    logic ready_random = 1'b0;
    logic watch_first = 1'b0;
    int edge_count = 0;
    int last_accept_cycle = 0;
    int first_result_cycle = 0;

    fp_misc_unit #(
        .OUTPUT_REGISTER_MODE(1)
    ) dut_i (
        .clk(clk),
        .rst_n(rst_n),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd(cmd),
        .result_valid(result_valid),
        .result_ready(result_ready),
        .result(result)
    );

    always #2 clk = ~clk;

    // Counts rising edges; it moves on the falling edge so readers agree.
    always @(negedge clk) begin
        edge_count <= edge_count + 1;
    end

    always @(negedge clk) begin
        if (ready_random) begin
            ready_state = lcg_next(ready_state);
            result_ready <= ready_state[16];
        end else begin
            result_ready <= 1'b1;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] random_word();
        operand_state = lcg_next(operand_state);
        return operand_state;
    endfunction

    function automatic logic is_nan(input logic [31:0] bits);
        return (bits[30:23] == 8'hff) && (bits[22:0] != 23'd0);
    endfunction

    // Unsigned keys that sort in IEEE order, -0 below +0.
    function automatic logic [31:0] order_key(input logic [31:0] bits);
        return bits[31] ? ~bits : {1'b1, bits[30:0]};
    endfunction

    function automatic fp_number_t int_reference(input logic [31:0] v, input logic is_signed);
        fp_number_t n;
        logic [31:0] mag;
        int pos;
        n = '0;
        mag = (is_signed && v[31]) ? (32'd0 - v) : v;
        if (mag == 32'd0) begin
            return n;
        end
        pos = 31;
        while (!mag[pos]) begin
            pos--;
        end
        n.value.sign = is_signed && v[31];
        n.value.exponent = 8'(127 + pos);
        if (pos >= 23) begin
            n.value.mantissa = 23'(mag >> (pos - 23));
        end else begin
            n.value.mantissa = 23'(mag << (23 - pos));
        end
        return n;
    endfunction

    function automatic fp_result_t expected_result(input fp_request_t req);
        fp_result_t r;
        logic [31:0] key_a;
        logic [31:0] key_b;
        r.dest_reg_addr = req.dest_reg_addr;
        r.dest_offset_addr = req.dest_offset_addr;
        r.result.nan = 1'b0;
        r.result.value = req.a_bits;
        key_a = order_key(req.a_bits);
        key_b = order_key(req.b_bits);
        case (req.op)
            FP_OP_MIN, FP_OP_MAX: begin
                if (is_nan(req.a_bits) || is_nan(req.b_bits)) begin
                    r.result.nan = 1'b1;
                    r.result.value = 32'h7fc00000;
                end else if ((req.op == FP_OP_MIN) ? (key_b < key_a) : (key_b > key_a)) begin
                    r.result.value = req.b_bits;
                end
            end
            FP_OP_RAW: r.result.nan = is_nan(req.a_bits);
            default: r.result = int_reference(req.a_bits, req.signed_integer);
        endcase
        return r;
    endfunction

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    // Drives one command from a falling edge and holds it until accepted.
    task automatic issue(input fp_op_t op, input logic is_signed, input logic [31:0] a,
                         input logic [31:0] b, output int stalls);
        fp_request_t req;
        logic accepted;
        req.op = op;
        req.signed_integer = is_signed;
        req.a_bits = a;
        req.b_bits = b;
        {req.dest_reg_addr, req.dest_offset_addr} = tag_counter;
        tag_counter++;
        stalls = 0;
        accepted = 1'b0;
        cmd = req;
        cmd_valid = 1'b1;
        expected_q.push_back(expected_result(req));
        while (!accepted) begin
            @(posedge clk);
            accepted = cmd_ready;
            if (!accepted) begin
                stalls++;
            end
        end
        last_accept_cycle = edge_count;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < 100) begin
            @(negedge clk);
            waited++;
        end
    endtask

    always @(posedge clk) begin : monitor
        fp_result_t want;
        if (rst_n && result_valid && result_ready) begin
            if (expected_q.size() == 0) begin
                $display("a result arrived with no command pending at %0t ns", $time);
                abort_run();
            end else begin
                if (watch_first) begin
                    first_result_cycle = edge_count;
                    watch_first = 1'b0;
                end
                want = expected_q.pop_front();
                check_value(64'(result), 64'(want), "result");
            end
        end
    end

    task automatic test_reset_and_raw();
        int stalls;
        check_value(64'(result_valid), 64'(1'b0), "result_valid after reset");
        check_value(64'(cmd_ready), 64'(1'b1), "cmd_ready after reset");
        for (int i = 0; i < N_RAW; i++) begin
            issue(FP_OP_RAW, 1'b0, RAW_PATTERNS[i], random_word(), stalls);
        end
        drain();
    endtask

    task automatic test_min_max();
        int stalls;
        for (int i = 0; i < N_PAIRS; i++) begin
            issue(FP_OP_MIN, 1'b0, PAIR_A[i], PAIR_B[i], stalls);
            issue(FP_OP_MAX, 1'b0, PAIR_A[i], PAIR_B[i], stalls);
        end
        drain();
    endtask

    task automatic test_int_convert();
        int stalls;
        for (int i = 0; i < N_CNV_FIXED; i++) begin
            issue(FP_OP_CNV, CNV_SIGNED[i], CNV_VALUES[i], 32'd0, stalls);
        end
        for (int i = 0; i < N_CNV_RANDOM; i++) begin
            issue(FP_OP_CNV, 1'(i % 2), random_word(), 32'd0, stalls);
        end
        drain();
    endtask

    task automatic test_backpressure();
        int stalls;
        logic [31:0] pick;
        ready_random = 1'b1;
        for (int i = 0; i < N_BURST; i++) begin
            pick = random_word();
            issue(fp_op_t'(pick[17:16]), pick[20], random_word(), random_word(), stalls);
        end
        ready_random = 1'b0;
        drain();
    endtask

    task automatic test_throughput();
        int stalls;
        int total_stalls;
        int first_accept;
        total_stalls = 0;
        first_accept = 0;
        watch_first = 1'b1;
        for (int i = 0; i < N_STREAM; i++) begin
            issue(fp_op_t'(2'(i)), 1'b1, random_word(), random_word(), stalls);
            if (i == 0) begin
                first_accept = last_accept_cycle;
            end
            total_stalls += stalls;
        end
        drain();
        check_value(64'(total_stalls), 64'(0), "cmd_ready stalls in back-to-back stream");
        check_value(64'(first_result_cycle - first_accept), 64'(2), "first result latency");
    endtask

    initial begin
        rst_n = 1'b0;
        cmd_valid = 1'b0;
        cmd = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset_and_raw();
        test_min_max();
        test_int_convert();
        test_backpressure();
        test_throughput();
        drain();
        if (expected_q.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("%0d expected results never arrived", expected_q.size());
            abort_run();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

endmodule

// File: dv/fp_misc_unit_assertions.sv
module fp_misc_unit_assertions
    import fpu_misc_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic result_valid,
    input logic result_ready,
    input fp_result_t result
);

    timeunit 1ns;
    timeprecision 1ps;

    property idle_in_reset;
        @(posedge clk) !rst_n |-> !result_valid;
    endproperty

    // A stalled result must not move or vanish.
    property hold_while_stalled;
        @(posedge clk) disable iff (!rst_n)
            (result_valid && !result_ready) |=> (result_valid && $stable(result));
    endproperty

    property valid_known;
        @(posedge clk) disable iff (!rst_n) !$isunknown(result_valid);
    endproperty

    idle_in_reset_a: assert property (idle_in_reset)
        else $error("result_valid high during reset");
    hold_while_stalled_a: assert property (hold_while_stalled)
        else $error("result changed while result_ready was low");
    valid_known_a: assert property (valid_known)
        else $error("result_valid is unknown after reset");

endmodule

bind fp_misc_unit fp_misc_unit_assertions assertions_i (
    .clk(clk),
    .rst_n(rst_n),
    .result_valid(result_valid),
    .result_ready(result_ready),
    .result(result)
);

// File: verilog/fp_misc_unit.sv
module fp_misc_unit
    import fpu_misc_pkg::*;
#(
    parameter int OUTPUT_REGISTER_MODE = 1
)(
    input logic clk,
    input logic rst_n,

    input logic cmd_valid,
    output logic cmd_ready,
    input fp_request_t cmd,

    output logic result_valid,
    input logic result_ready,
    output fp_result_t result
);

    fp_convert_command_t unpacked_cmd;
    fp_convert_command_t staged_cmd;
    logic staged_valid;
    logic staged_ready;
    fp_result_t next_result;

    fp_unpack fp_unpack_i (
        .request(cmd),
        .command(unpacked_cmd)
    );

    // Unpack and convert are single-cycle and always ready, so the stage
    // registers carry all of the handshake.
    flow_stage #(
        .payload_t(fp_convert_command_t),
        .MODE(1)
    ) command_stage_i (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(cmd_valid),
        .in_ready(cmd_ready),
        .in_payload(unpacked_cmd),
        .out_valid(staged_valid),
        .out_ready(staged_ready),
        .out_payload(staged_cmd)
    );

    fp_convert fp_convert_i (
        .command(staged_cmd),
        .result(next_result)
    );

    flow_stage #(
        .payload_t(fp_result_t),
        .MODE(OUTPUT_REGISTER_MODE)
    ) output_stage_i (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(staged_valid),
        .in_ready(staged_ready),
        .in_payload(next_result),
        .out_valid(result_valid),
        .out_ready(result_ready),
        .out_payload(result)
    );

endmodule

// File: verilog/fp_convert.sv
module fp_convert
    import fpu_misc_pkg::*;
(
    input fp_convert_command_t command,
    output fp_result_t result
);

    // IEEE total order for non-NaN values with -0 below +0.
    function automatic logic ieee_less(input fp_value_t x, input fp_value_t y);
        logic [30:0] x_mag;
        logic [30:0] y_mag;
        x_mag = {x.exponent, x.mantissa};
        y_mag = {y.exponent, y.mantissa};
        if (x.sign != y.sign) begin
            return x.sign;
        end else if (x.sign) begin
            return x_mag > y_mag;
        end else begin
            return x_mag < y_mag;
        end
    endfunction

    logic a_lt_b;
    logic b_lt_a;
    logic any_nan;
    fp_number_t converted;
    fp_number_t number;

    assign a_lt_b = ieee_less(command.a, command.b);
    assign b_lt_a = ieee_less(command.b, command.a);
    assign any_nan = command.conditions_a.nan || command.conditions_b.nan;

    int_to_float int_to_float_i (
        .value(32'(command.a)),
        .is_signed(command.signed_integer),
        .number(converted)
    );

    always_comb begin
        number.nan = 1'b0;
        number.value = command.a;

        case (command.op)
            FP_OP_MIN: begin
                if (any_nan) begin
                    number.nan = 1'b1;
                    number.value = FP_QNAN;
                end else if (b_lt_a) begin
                    number.value = command.b;
                end
            end
            FP_OP_MAX: begin
                if (any_nan) begin
                    number.nan = 1'b1;
                    number.value = FP_QNAN;
                end else if (a_lt_b) begin
                    number.value = command.b;
                end
            end
            FP_OP_RAW: begin
                number.nan = command.conditions_a.nan;
            end
            FP_OP_CNV: begin
                number = converted;
            end
        endcase
    end

    assign result.dest_reg_addr = command.dest_reg_addr;
    assign result.dest_offset_addr = command.dest_offset_addr;
    assign result.result = number;

endmodule

// File: verilog/int_to_float.sv
module int_to_float
    import fpu_misc_pkg::*;
(
    input logic [31:0] value,
    input logic is_signed,
    output fp_number_t number
);

    logic negative;
    logic [31:0] magnitude;
    logic [4:0] lead_pos;
    logic [31:0] normalized;
    logic is_zero;

    // Only a signed input with bit 31 set is treated as negative.
    assign negative = is_signed && value[31];
    assign magnitude = negative ? (~value + 32'd1) : value;
    assign is_zero = ~|magnitude;

    // Leading-one detector; the highest set bit wins.
    always_comb begin
        lead_pos = '0;
        for (int i = 0; i < 32; i++) begin
            if (magnitude[i]) begin
                lead_pos = 5'(i);
            end
        end
    end

    // Move the leading one to bit 31, the hidden bit.
    assign normalized = magnitude << (5'd31 - lead_pos);

    always_comb begin
        number.nan = 1'b0;
        if (is_zero) begin
            number.value.sign = 1'b0;
            number.value.exponent = '0;
            number.value.mantissa = '0;
        end else begin
            number.value.sign = negative;
            number.value.exponent = FP_EXP_W'(FP_EXP_BIAS) + FP_EXP_W'(lead_pos);
            // Bits below the mantissa are dropped, i.e. round toward zero.
            number.value.mantissa = normalized[30 -: FP_MANT_W];
        end
    end

endmodule

// File: verilog/fp_unpack.sv
module fp_unpack
    import fpu_misc_pkg::*;
(
    input fp_request_t request,
    output fp_convert_command_t command
);

    function automatic fp_value_t split_bits(input logic [31:0] bits);
        fp_value_t v;
        v.sign = bits[31];
        v.exponent = bits[30:FP_MANT_W];
        v.mantissa = bits[FP_MANT_W-1:0];
        return v;
    endfunction

    function automatic fp_conditions_t classify(input fp_value_t v);
        fp_conditions_t c;
        logic exp_ones;
        logic exp_zero;
        logic mant_zero;
        exp_ones = &v.exponent;
        exp_zero = ~|v.exponent;
        mant_zero = ~|v.mantissa;
        c.nan = exp_ones && !mant_zero;
        c.inf = exp_ones && mant_zero;
        c.zero = exp_zero && mant_zero;
        c.subnormal = exp_zero && !mant_zero;
        return c;
    endfunction

    fp_value_t a_value;
    fp_value_t b_value;

    assign a_value = split_bits(request.a_bits);
    assign b_value = split_bits(request.b_bits);

    always_comb begin
        command.op = request.op;
        command.signed_integer = request.signed_integer;
        command.a = a_value;
        command.b = b_value;
        command.conditions_a = classify(a_value);
        command.conditions_b = classify(b_value);

        // Tags ride along untouched.
        command.dest_reg_addr = request.dest_reg_addr;
        command.dest_offset_addr = request.dest_offset_addr;
    end

endmodule

// File: verilog/flow_stage.sv
module flow_stage #(
    parameter type payload_t = logic,
    parameter int MODE = 1
)(
    input logic clk,
    input logic rst_n,

    input logic in_valid,
    output logic in_ready,
    input payload_t in_payload,

    output logic out_valid,
    input logic out_ready,
    output payload_t out_payload
);

    generate
        if (MODE == 1) begin : g_registered
            logic valid_q;
            payload_t payload_q;

            // Accept when empty or when the current entry leaves this cycle.
            assign in_ready = !valid_q || out_ready;

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    valid_q <= 1'b0;
                end else if (in_ready) begin
                    valid_q <= in_valid;
                end
            end

            always_ff @(posedge clk) begin
                if (in_ready && in_valid) begin
                    payload_q <= in_payload;
                end
            end

            assign out_valid = valid_q;
            assign out_payload = payload_q;
        end else begin : g_bypass
            // Pure combinational path, no storage.
            assign out_valid = in_valid;
            assign in_ready = out_ready;
            assign out_payload = in_payload;
        end
    endgenerate

endmodule

// File: verilog/fpu_misc_pkg.sv
package fpu_misc_pkg;

    // Destination tag widths.
    localparam int REG_ADDR_W = 5;
    localparam int OFFSET_ADDR_W = 3;

    // Single-precision field widths.
    localparam int FP_EXP_W = 8;
    localparam int FP_MANT_W = 23;
    localparam int FP_EXP_BIAS = 127;

    typedef enum logic [1:0] {
        FP_OP_MIN = 2'd0,
        FP_OP_MAX = 2'd1,
        FP_OP_RAW = 2'd2,
        FP_OP_CNV = 2'd3
    } fp_op_t;

    typedef struct packed {
        logic sign;
        logic [FP_EXP_W-1:0] exponent;
        logic [FP_MANT_W-1:0] mantissa;
    } fp_value_t;

    typedef struct packed {
        logic nan;
        logic inf;
        logic zero;
        logic subnormal;
    } fp_conditions_t;

    typedef struct packed {
        fp_op_t op;
        logic signed_integer;
        logic [31:0] a_bits;
        logic [31:0] b_bits;
        logic [REG_ADDR_W-1:0] dest_reg_addr;
        logic [OFFSET_ADDR_W-1:0] dest_offset_addr;
    } fp_request_t;

    typedef struct packed {
        fp_op_t op;
        logic signed_integer;
        fp_value_t a;
        fp_value_t b;
        fp_conditions_t conditions_a;
        fp_conditions_t conditions_b;
        logic [REG_ADDR_W-1:0] dest_reg_addr;
        logic [OFFSET_ADDR_W-1:0] dest_offset_addr;
    } fp_convert_command_t;

    typedef struct packed {
        logic nan;
        fp_value_t value;
    } fp_number_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] dest_reg_addr;
        logic [OFFSET_ADDR_W-1:0] dest_offset_addr;
        fp_number_t result;
    } fp_result_t;

    // Canonical quiet NaN returned by min and max.
    localparam fp_value_t FP_QNAN = '{sign: 1'b0, exponent: 8'hff, mantissa: 23'h400000};

endpackage
